// ==== denise_settings.svh ====
`ifndef DENISE_SETTINGS_SVH
`define DENISE_SETTINGS_SVH

// register addresses are bits 8..1 of the chip register offset

// --------------------
// control registers
// --------------------
`define DENISE_BPLCON0 8'h80 // $100, only HAM enable is kept
`define DENISE_BPLCON2 8'h82 // $104, playfield 1 priority
`define DENISE_CLXCON 8'h4C // $098, collision control
`define DENISE_CLXDAT 8'h07 // $00E, collision data, read only
`define DENISE_DENISEID 8'h3E // $07C, chip id, read only

// --------------------
// palette and bus
// --------------------
`define DENISE_COLOR_BASE 8'hC0 // $180, COLOR00
`define DENISE_IDLE_ADDR 8'hFF // bus cycle that touches nothing

// --------------------
// values
// --------------------
`define DENISE_ID_VALUE 16'hFFFC // ECS Denise id
`define DENISE_CLXCON_RESET 16'h0FFF // all planes enabled, match on 1s

`endif

// ==== denise_pkg.sv ====
package denise_pkg;

	// bus side
	typedef logic [7:0] reg_addr_t; // register offset bits 8..1
	typedef logic [15:0] bus_data_t; // chip bus data word

	// colour, red in the top nibble
	typedef struct packed
	{
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// pixel side
	typedef logic [5:0] bpl_t; // bit 0 is plane 1
	typedef logic [7:0] spr_mask_t; // one valid bit per sprite
	typedef logic [3:0] spr_pix_t; // sprite colour code

	// palette select
	// bits 4..0 pick one of 32 colour registers
	// bit 5 asks for extra half brite
	typedef logic [5:0] clut_sel_t;

endpackage

// ==== denise_regs.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// control register bank
// holds the BPLCON0 and BPLCON2 bits the pixel path still needs
// and answers reads of the chip id register

module denise_regs
(
	input	logic					clk,
	input	logic					reset,
	input	denise_pkg::reg_addr_t	reg_address, // register address, bits 8..1
	input	denise_pkg::bus_data_t	data_in, // bus write data
	output	logic					ham_mode, // hold and modify enable
	output	logic	[2:0]			pf1_pri, // playfield 1 vs sprite priority
	output	denise_pkg::bus_data_t	data_out // read data, 0 when not addressed
);
	import denise_pkg::*;

	localparam reg_addr_t ADDR_BPLCON0 = `DENISE_BPLCON0;
	localparam reg_addr_t ADDR_BPLCON2 = `DENISE_BPLCON2;
	localparam reg_addr_t ADDR_ID = `DENISE_DENISEID;
	localparam bus_data_t ID_VALUE = `DENISE_ID_VALUE;

	// --------------------
	// BPLCON0
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			ham_mode <= 1'b0;
		else if (reg_address == ADDR_BPLCON0)
			ham_mode <= data_in[11]; // HOMOD bit
	end

	// --------------------
	// BPLCON2
	// --------------------
	// only PF1P2..PF1P0 survive, single playfield display
	always_ff @(posedge clk)
	begin
		if (reset)
			pf1_pri <= 3'd0;
		else if (reg_address == ADDR_BPLCON2)
			pf1_pri <= data_in[2:0];
	end

	// --------------------
	// read path
	// --------------------
	// id read is combinational in the address cycle
	assign data_out = (reg_address == ADDR_ID) ? ID_VALUE : '0;

endmodule

// ==== palette_ram.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// colour register file, written from the bus, read without a clock
// depth is 2**ADDR_BITS entries counted from COLOR00

module palette_ram
#(
	parameter int ADDR_BITS = 5 // 5 for the full table, 4 for the HAM copy
)
(
	input	logic					clk,
	input	denise_pkg::reg_addr_t	reg_address, // register address, bits 8..1
	input	denise_pkg::bus_data_t	data_in, // bus write data
	input	logic	[ADDR_BITS-1:0]	index, // read select
	output	denise_pkg::rgb_t		color // selected colour
);
	import denise_pkg::*;

	localparam reg_addr_t COLOR_BASE = `DENISE_COLOR_BASE;

	rgb_t mem [2**ADDR_BITS]; // colour registers, no reset

	// upper address bits pick the colour block, low bits the entry
	always_ff @(posedge clk)
	begin
		if (reg_address[7:ADDR_BITS] == COLOR_BASE[7:ADDR_BITS])
			mem[reg_address[ADDR_BITS-1:0]] <= rgb_t'(data_in[11:0]); // 12 bit RGB
	end

	assign color = mem[index]; // asynchronous read

endmodule

// ==== color_lookup.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// sprite vs playfield priority, palette index selection,
// 32 entry colour table and the extra half brite output register

module color_lookup
(
	input	logic					clk,
	input	denise_pkg::reg_addr_t	reg_address, // register address, bits 8..1
	input	denise_pkg::bus_data_t	data_in, // bus write data
	input	denise_pkg::bpl_t		bpldata, // bitplane pixel
	input	denise_pkg::spr_pix_t	sprdata, // sprite colour code
	input	denise_pkg::spr_mask_t	nsprite, // sprite valid bits
	input	logic	[2:0]			pf1_pri, // BPLCON2 playfield 1 priority
	output	denise_pkg::rgb_t		clut_rgb, // registered colour
	output	logic					spr_sel // sprite wins this pixel
);
	import denise_pkg::*;

	logic [3:0] spr_group; // one bit per sprite pair
	logic [2:0] spr_code; // 1..4 for the front pair, 7 when none
	logic pf_front; // playfield sits in front of the sprite
	clut_sel_t clut_sel; // palette index with half brite flag
	rgb_t sel_color; // raw palette output

	// --------------------
	// sprite priority
	// --------------------
	assign spr_group[0] = |nsprite[1:0];
	assign spr_group[1] = |nsprite[3:2];
	assign spr_group[2] = |nsprite[5:4];
	assign spr_group[3] = |nsprite[7:6];

	// lowest pair has the highest priority
	always_comb
	begin
		if (spr_group[0])
			spr_code = 3'd1;
		else if (spr_group[1])
			spr_code = 3'd2;
		else if (spr_group[2])
			spr_code = 3'd3;
		else if (spr_group[3])
			spr_code = 3'd4;
		else
			spr_code = 3'd7; // no sprite at all
	end

	// non zero playfield beats sprites ranked below pf1_pri
	assign pf_front = (bpldata != '0) && (spr_code > pf1_pri);
	assign spr_sel = (spr_code != 3'd7) && !pf_front;

	// --------------------
	// palette
	// --------------------
	// sprites use colours 16..31
	assign clut_sel = spr_sel ? {2'b01, sprdata} : clut_sel_t'(bpldata);

	palette_ram #(
		.ADDR_BITS	(5)
	) u_palette (
		.clk		(clk),
		.reg_address(reg_address),
		.data_in	(data_in),
		.index		(clut_sel[4:0]),
		.color		(sel_color)
	);

	// half brite shifts every component one place right
	always_ff @(posedge clk)
	begin
		if (clut_sel[5])
		begin
			clut_rgb.r <= {1'b0, sel_color.r[3:1]};
			clut_rgb.g <= {1'b0, sel_color.g[3:1]};
			clut_rgb.b <= {1'b0, sel_color.b[3:1]};
		end
		else
			clut_rgb <= sel_color; // normal colour
	end

endmodule

// ==== ham_generator.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// hold and modify decoder
// keeps its own copy of COLOR00..15 so sprites can use the main table
// while the HAM playfield is loading base colours

module ham_generator
(
	input	logic					clk,
	input	logic					reset,
	input	denise_pkg::reg_addr_t	reg_address, // register address, bits 8..1
	input	denise_pkg::bus_data_t	data_in, // bus write data
	input	denise_pkg::bpl_t		bpldata, // bitplane pixel, bits 5..4 are the command
	output	denise_pkg::rgb_t		ham_rgb // held colour
);
	import denise_pkg::*;

	rgb_t base_color; // palette entry for a load command

	palette_ram #(
		.ADDR_BITS	(4)
	) u_palette (
		.clk		(clk),
		.reg_address(reg_address),
		.data_in	(data_in),
		.index		(bpldata[3:0]),
		.color		(base_color)
	);

	// --------------------
	// hold register
	// --------------------
	// untouched components keep the previous pixel colour
	always_ff @(posedge clk)
	begin
		if (reset)
			ham_rgb <= '0;
		else
		begin
			case (bpldata[5:4])
				2'b00: ham_rgb <= base_color; // load from palette
				2'b01: ham_rgb.b <= bpldata[3:0]; // modify blue
				2'b10: ham_rgb.r <= bpldata[3:0]; // modify red
				default: ham_rgb.g <= bpldata[3:0]; // 11, modify green
			endcase
		end
	end

endmodule

// ==== collision_detect.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// sprite and bitplane collision detection
// CLXCON selects what counts as a hit, CLXDAT collects hits until read

module collision_detect
(
	input	logic					clk,
	input	logic					reset,
	input	denise_pkg::reg_addr_t	reg_address, // register address, bits 8..1
	input	denise_pkg::bus_data_t	data_in, // bus write data
	input	denise_pkg::bpl_t		bpldata, // bitplane pixel
	input	denise_pkg::spr_mask_t	nsprite, // sprite valid bits
	output	denise_pkg::bus_data_t	data_out // CLXDAT read data
);
	import denise_pkg::*;

	localparam reg_addr_t ADDR_CLXCON = `DENISE_CLXCON;
	localparam reg_addr_t ADDR_CLXDAT = `DENISE_CLXDAT;

	bus_data_t clxcon; // control register
	logic [14:0] clxdat; // sticky collision bits
	logic [5:0] plane_match; // per plane match
	logic odd_match; // planes 1, 3, 5
	logic even_match; // planes 2, 4, 6
	logic [3:0] spr_match; // per sprite pair
	logic [14:0] hit; // collisions in this pixel
	logic clx_read;

	always_ff @(posedge clk)
	begin
		if (reset)
			clxcon <= `DENISE_CLXCON_RESET;
		else if (reg_address == ADDR_CLXCON)
			clxcon <= data_in;
	end

	// --------------------
	// matching
	// --------------------
	// disabled plane always matches, enabled plane must equal MVBPn
	assign plane_match = ~clxcon[11:6] | ~(bpldata ^ clxcon[5:0]);
	assign odd_match = plane_match[0] & plane_match[2] & plane_match[4];
	assign even_match = plane_match[1] & plane_match[3] & plane_match[5];

	// odd sprite joins its pair only when ENSPn is set
	assign spr_match[0] = nsprite[0] | (nsprite[1] & clxcon[12]);
	assign spr_match[1] = nsprite[2] | (nsprite[3] & clxcon[13]);
	assign spr_match[2] = nsprite[4] | (nsprite[5] & clxcon[14]);
	assign spr_match[3] = nsprite[6] | (nsprite[7] & clxcon[15]);

	assign hit[0] = even_match & odd_match; // even planes vs odd planes
	assign hit[1] = odd_match & spr_match[0];
	assign hit[2] = odd_match & spr_match[1];
	assign hit[3] = odd_match & spr_match[2];
	assign hit[4] = odd_match & spr_match[3];
	assign hit[5] = even_match & spr_match[0];
	assign hit[6] = even_match & spr_match[1];
	assign hit[7] = even_match & spr_match[2];
	assign hit[8] = even_match & spr_match[3];
	// sprite pair against sprite pair
	assign hit[9] = spr_match[0] & spr_match[1];
	assign hit[10] = spr_match[0] & spr_match[2];
	assign hit[11] = spr_match[0] & spr_match[3];
	assign hit[12] = spr_match[1] & spr_match[2];
	assign hit[13] = spr_match[1] & spr_match[3];
	assign hit[14] = spr_match[2] & spr_match[3];

	// --------------------
	// CLXDAT
	// --------------------
	assign clx_read = (reg_address == ADDR_CLXDAT);

	// a read clears everything, hits in the read cycle are dropped
	always_ff @(posedge clk)
	begin
		if (reset || clx_read)
			clxdat <= '0;
		else
			clxdat <= clxdat | hit;
	end

	assign data_out = clx_read ? {1'b1, clxdat} : '0; // bit 15 reads as 1

endmodule

// ==== rgb_output.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// final video stage
// picks the HAM or palette colour and applies blanking

module rgb_output
(
	input	logic				clk,
	input	logic				reset,
	input	denise_pkg::rgb_t	clut_rgb, // palette colour, already registered
	input	denise_pkg::rgb_t	ham_rgb, // HAM colour, already registered
	input	logic				spr_sel, // sprite select, pixel cycle
	input	logic				blank, // blanking, pixel cycle
	input	logic				ham_mode, // BPLCON0 HOMOD
	output	denise_pkg::rgb_t	rgb // video out
);
	import denise_pkg::*;

	logic spr_sel_d; // lines up with the registered colours
	logic blank_d;
	rgb_t mux_rgb;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			spr_sel_d <= 1'b0;
			blank_d <= 1'b0;
		end
		else
		begin
			spr_sel_d <= spr_sel;
			blank_d <= blank;
		end
	end

	// sprites keep palette colours in HAM mode
	assign mux_rgb = (ham_mode && !spr_sel_d) ? ham_rgb : clut_rgb;

	always_ff @(posedge clk)
	begin
		if (reset || blank_d)
			rgb <= '0; // black
		else
			rgb <= mux_rgb;
	end

endmodule

// ==== denise_video.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

// pixel back end top level
// serial pixel data comes in on ports, one pixel per clock

module denise_video
(
	input	logic					clk,
	input	logic					reset,
	input	logic					blank, // blanking for this pixel
	input	denise_pkg::reg_addr_t	reg_address, // register address, bits 8..1
	input	denise_pkg::bus_data_t	data_in, // bus write data
	input	denise_pkg::bpl_t		bpldata, // bitplane pixel
	input	denise_pkg::spr_pix_t	sprdata, // sprite colour code
	input	denise_pkg::spr_mask_t	nsprite, // sprite valid bits
	output	denise_pkg::bus_data_t	data_out, // register read data
	output	denise_pkg::rgb_t		rgb // video out, 2 clocks after the pixel
);
	import denise_pkg::*;

	logic ham_mode;
	logic [2:0] pf1_pri;
	logic spr_sel;
	rgb_t clut_rgb;
	rgb_t ham_rgb;
	bus_data_t regs_data; // id read
	bus_data_t clx_data; // CLXDAT read

	// --------------------
	// register bus
	// --------------------
	denise_regs u_regs (
		.clk		(clk),
		.reset		(reset),
		.reg_address(reg_address),
		.data_in	(data_in),
		.ham_mode	(ham_mode),
		.pf1_pri	(pf1_pri),
		.data_out	(regs_data)
	);

	collision_detect u_clx (
		.clk		(clk),
		.reset		(reset),
		.reg_address(reg_address),
		.data_in	(data_in),
		.bpldata	(bpldata),
		.nsprite	(nsprite),
		.data_out	(clx_data)
	);

	assign data_out = regs_data | clx_data; // idle units drive 0

	// --------------------
	// pixel path
	// --------------------
	color_lookup u_clut (
		.clk		(clk),
		.reg_address(reg_address),
		.data_in	(data_in),
		.bpldata	(bpldata),
		.sprdata	(sprdata),
		.nsprite	(nsprite),
		.pf1_pri	(pf1_pri),
		.clut_rgb	(clut_rgb),
		.spr_sel	(spr_sel)
	);

	ham_generator u_ham (
		.clk		(clk),
		.reset		(reset),
		.reg_address(reg_address),
		.data_in	(data_in),
		.bpldata	(bpldata),
		.ham_rgb	(ham_rgb)
	);

	rgb_output u_out (
		.clk		(clk),
		.reset		(reset),
		.clut_rgb	(clut_rgb),
		.ham_rgb	(ham_rgb),
		.spr_sel	(spr_sel),
		.blank		(blank),
		.ham_mode	(ham_mode),
		.rgb		(rgb)
	);

endmodule

// ==== tb_denise_video.sv ====
`timescale 1ns/1ps
`include "denise_settings.svh"

module tb_denise_video;
	import denise_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int PAL_ENTRIES = 32;
	localparam int MAX_ROWS = 48;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + PAL_ENTRIES + MAX_ROWS + 2 + 20; // + margin
	localparam reg_addr_t IDLE = `DENISE_IDLE_ADDR;
	localparam reg_addr_t ADDR_ID = `DENISE_DENISEID;
	localparam reg_addr_t ADDR_CLXDAT = `DENISE_CLXDAT;
	localparam reg_addr_t ADDR_CLXCON = `DENISE_CLXCON;
	localparam reg_addr_t ADDR_BPLCON0 = `DENISE_BPLCON0;
	localparam reg_addr_t ADDR_BPLCON2 = `DENISE_BPLCON2;
	localparam reg_addr_t COLOR_BASE = `DENISE_COLOR_BASE;

	// one table row: bus cycle, pixel, expected outputs
	typedef struct packed
	{
		reg_addr_t addr;
		bus_data_t data;
		bpl_t bpl;
		spr_pix_t spr;
		spr_mask_t nspr;
		logic blank;
		rgb_t exp_rgb; // seen 2 rows later
		bus_data_t exp_data; // seen in the same row
	} row_t;

	logic clk, reset, blank;
	reg_addr_t reg_address;
	bus_data_t data_in, data_out;
	bpl_t bpldata;
	spr_pix_t sprdata;
	spr_mask_t nsprite;
	rgb_t rgb;

	row_t rows [MAX_ROWS];
	row_t idle_row;
	int n_rows = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// reference model state
	rgb_t pal [PAL_ENTRIES]; // shadow of the colour registers
	rgb_t m_hold; // HAM hold register
	logic m_ham_mode;
	logic [2:0] m_pf1_pri;
	bus_data_t m_clxcon;
	logic [14:0] m_clxdat;

	denise_video u_dut (
		.clk		(clk),
		.reset		(reset),
		.blank		(blank),
		.reg_address(reg_address),
		.data_in	(data_in),
		.bpldata	(bpldata),
		.sprdata	(sprdata),
		.nsprite	(nsprite),
		.data_out	(data_out),
		.rgb		(rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic add_row(input reg_addr_t addr, input bus_data_t data, input bpl_t bpl,
		input spr_pix_t spr, input spr_mask_t nspr, input logic blk);
		rows[n_rows] = '{addr, data, bpl, spr, nspr, blk, '0, '0};
		n_rows = n_rows + 1;
	endtask

	task automatic drive_row(input row_t r);
		reg_address = r.addr;
		data_in = r.data;
		bpldata = r.bpl;
		sprdata = r.spr;
		nsprite = r.nspr;
		blank = r.blank;
	endtask

	// palette writes through the bus, colours from the LCG
	task automatic fill_palettes();
		logic [31:0] seed;
		seed = 32'd51;
		for (int k = 0; k < PAL_ENTRIES; k++)
		begin
			seed = lcg_next(seed);
			@(negedge clk);
			reg_address = COLOR_BASE + 8'(k);
			data_in = {4'h0, seed[27:16]};
			pal[k] = rgb_t'(seed[27:16]);
		end
	endtask

	// --------------------
	// stimulus table
	// --------------------
	task automatic build_table();
		add_row(ADDR_ID, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0); // chip id
		add_row(ADDR_CLXDAT, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0); // nothing collided yet
		add_row(IDLE, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0);
		add_row(IDLE, 16'h0, 6'h05, 4'h0, 8'h00, 1'b0); // plain palette colour
		add_row(IDLE, 16'h0, 6'h25, 4'h0, 8'h00, 1'b0); // half brite of entry 5
		add_row(IDLE, 16'h0, 6'h13, 4'h0, 8'h00, 1'b0);
		add_row(IDLE, 16'h0, 6'h3F, 4'h0, 8'h00, 1'b0); // all planes set
		// sprite priority with pf1_pri = 2
		add_row(ADDR_BPLCON2, 16'h0002, 6'h00, 4'h0, 8'h00, 1'b0);
		add_row(IDLE, 16'h0, 6'h03, 4'h4, 8'h01, 1'b0); // pair 0 in front
		add_row(IDLE, 16'h0, 6'h03, 4'h9, 8'h08, 1'b0); // pair 1, code equals pf1_pri
		add_row(IDLE, 16'h0, 6'h03, 4'h6, 8'h10, 1'b0); // pair 2 behind playfield
		add_row(IDLE, 16'h0, 6'h00, 4'hB, 8'h40, 1'b0); // empty playfield, sprite shows
		// --------------------
		// hold and modify
		// --------------------
		add_row(ADDR_BPLCON0, 16'h0800, 6'h07, 4'h0, 8'h00, 1'b0);
		add_row(IDLE, 16'h0, 6'h07, 4'h0, 8'h00, 1'b0); // load entry 7
		add_row(IDLE, 16'h0, 6'h2A, 4'h0, 8'h00, 1'b0); // red
		add_row(IDLE, 16'h0, 6'h35, 4'h0, 8'h00, 1'b0); // green
		add_row(IDLE, 16'h0, 6'h1C, 4'h0, 8'h00, 1'b0); // blue
		add_row(IDLE, 16'h0, 6'h23, 4'h2, 8'h01, 1'b0); // sprite keeps palette colour
		add_row(IDLE, 16'h0, 6'h19, 4'h0, 8'h00, 1'b0);
		add_row(ADDR_BPLCON0, 16'h0000, 6'h00, 4'h0, 8'h00, 1'b0);
		add_row(IDLE, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0);
		// collisions, odd planes only, match on 1
		add_row(ADDR_CLXDAT, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0); // flush earlier hits
		add_row(ADDR_CLXCON, 16'h0555, 6'h00, 4'h0, 8'h00, 1'b0);
		add_row(IDLE, 16'h0, 6'h15, 4'h1, 8'h04, 1'b0); // sprite 2 over planes 1,3,5
		add_row(IDLE, 16'h0, 6'h15, 4'h1, 8'h80, 1'b0); // odd sprite, ENSP7 off
		add_row(IDLE, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0);
		add_row(ADDR_CLXDAT, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0);
		add_row(ADDR_CLXDAT, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0); // cleared by the last read
		// blanking
		add_row(IDLE, 16'h0, 6'h05, 4'h0, 8'h00, 1'b1);
		add_row(IDLE, 16'h0, 6'h06, 4'h3, 8'h01, 1'b1);
		add_row(IDLE, 16'h0, 6'h05, 4'h0, 8'h00, 1'b0);
	endtask

	// --------------------
	// reference model
	// --------------------
	task automatic predict_table();
		logic [2:0] code;
		logic spr_wins, odd, even, pm;
		logic [3:0] grp;
		logic [14:0] hits;
		clut_sel_t idx;
		rgb_t c;
		int k;
		for (int i = 0; i < n_rows; i++)
		begin
			code = 3'd7;
			for (int p = 3; p >= 0; p--)
				if (rows[i].nspr[2*p] | rows[i].nspr[2*p+1])
					code = 3'(p + 1); // lowest pair wins
			spr_wins = (code != 3'd7) && !((rows[i].bpl != 6'h00) && (code > m_pf1_pri));
			idx = spr_wins ? {2'b01, rows[i].spr} : rows[i].bpl;
			c = pal[idx[4:0]];
			if (idx[5])
				c = {1'b0, c.r[3:1], 1'b0, c.g[3:1], 1'b0, c.b[3:1]};
			case (rows[i].bpl[5:4])
				2'b00: m_hold = pal[rows[i].bpl[3:0]];
				2'b01: m_hold.b = rows[i].bpl[3:0];
				2'b10: m_hold.r = rows[i].bpl[3:0];
				default: m_hold.g = rows[i].bpl[3:0];
			endcase
			// collision pairs
			odd = 1'b1;
			even = 1'b1;
			for (int p = 0; p < 6; p++)
			begin
				pm = !m_clxcon[6+p] || (rows[i].bpl[p] == m_clxcon[p]);
				if (p % 2 == 0)
					odd = odd & pm;
				else
					even = even & pm;
			end
			for (int g = 0; g < 4; g++)
				grp[g] = rows[i].nspr[2*g] | (rows[i].nspr[2*g+1] & m_clxcon[12+g]);
			hits[0] = odd & even;
			for (int g = 0; g < 4; g++)
			begin
				hits[1+g] = odd & grp[g];
				hits[5+g] = even & grp[g];
			end
			k = 9;
			for (int a = 0; a < 3; a++)
				for (int b = a + 1; b < 4; b++)
				begin
					hits[k] = grp[a] & grp[b];
					k = k + 1;
				end
			rows[i].exp_data = (rows[i].addr == ADDR_ID) ? 16'hFFFC : 16'h0000;
			if (rows[i].addr == ADDR_CLXDAT)
			begin
				rows[i].exp_data = rows[i].exp_data | {1'b1, m_clxdat};
				m_clxdat = 15'h0; // hits of the read cycle are lost
			end
			else
				m_clxdat = m_clxdat | hits;
			// register writes land at the end of the row
			if (rows[i].addr == ADDR_BPLCON0)
				m_ham_mode = rows[i].data[11];
			if (rows[i].addr == ADDR_BPLCON2)
				m_pf1_pri = rows[i].data[2:0];
			if (rows[i].addr == ADDR_CLXCON)
				m_clxcon = rows[i].data;
			if (rows[i].addr[7:5] == COLOR_BASE[7:5])
				pal[rows[i].addr[4:0]] = rgb_t'(rows[i].data[11:0]);
			// output stage sees ham_mode after this row's write
			if (rows[i].blank)
				rows[i].exp_rgb = '0;
			else
				rows[i].exp_rgb = (m_ham_mode && !spr_wins) ? m_hold : c;
		end
	endtask

	initial
	begin
		idle_row = '{IDLE, 16'h0, 6'h00, 4'h0, 8'h00, 1'b0, '0, '0};
		reset = 1'b1;
		drive_row(idle_row);
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		fill_palettes();
		// model state right after the fill, bpldata 0 kept loading entry 0
		m_hold = pal[0];
		m_ham_mode = 1'b0;
		m_pf1_pri = 3'd0;
		m_clxcon = `DENISE_CLXCON_RESET;
		m_clxdat = 15'h0;
		build_table();
		predict_table();
		for (int j = 0; j < n_rows + 2; j++)
		begin
			@(negedge clk);
			if (j >= 2)
				check_value("rgb", {4'h0, rgb}, {4'h0, rows[j-2].exp_rgb}); // 2 rows back
			if (j < n_rows)
			begin
				drive_row(rows[j]);
				#1;
				check_value("data_out", data_out, rows[j].exp_data);
			end
			else
				drive_row(idle_row);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== denise_video.f ====
+incdir+.
denise_pkg.sv
denise_regs.sv
palette_ram.sv
color_lookup.sv
ham_generator.sv
collision_detect.sv
rgb_output.sv
denise_video.sv
tb_denise_video.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_denise_video
FILELIST  = denise_video.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
